/* mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// boot vector, first word fetched after reset
`define MIPS_RESET_PC 32'hBFC00000

`define MIPS_NUM_REGS 32 // general purpose registers

`define MIPS_BE_W 4 // byte enables per sram word

`endif

/* mips_pkg.sv */
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [31:0] word_t; // data, address or instruction
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,      // value read in decode
        FWD_FROM_MEM, // alu result of the memory stage
        FWD_FROM_WB   // final writeback value
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    dst_rt; // rt is the destination, not rd
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } ifid_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t dst;
    } idex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dst;
    } exmem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     reg_write;
        logic     mem_read;
        word_t    alu_result; // load data comes straight from the sram
        reg_idx_t dst;
    } memwb_t;

endpackage

/* mips_fetch.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module mips_fetch (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            stall_i,
    input  logic            jump_i,
    input  mips_pkg::word_t jump_target_i,
    input  logic            branch_taken_i,
    input  mips_pkg::word_t branch_target_i,
    output mips_pkg::word_t pc_o,
    output mips_pkg::word_t next_pc_o
);
    import mips_pkg::*;

    word_t pc_q; // address of the word the sram returns this cycle

    always_comb begin
        if (branch_taken_i) begin
            next_pc_o = branch_target_i;
        end else if (jump_i) begin
            next_pc_o = jump_target_i;
        end else begin
            next_pc_o = pc_q + 32'd4;
        end
    end

    // one word before the boot vector so the first request lands on it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `MIPS_RESET_PC - 32'd4;
        end else if (!stall_i) begin
            pc_q <= next_pc_o;
        end
    end

    assign pc_o = pc_q;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i) pc_q[1:0] == 2'b00
    );

endmodule

/* mips_decoder.sv */
`timescale 1ns/100ps

module mips_decoder (
    input  mips_pkg::word_t    instr_i,
    output mips_pkg::ctrl_t    ctrl_o,
    output mips_pkg::word_t    imm_o,
    output mips_pkg::reg_idx_t rs_o,
    output mips_pkg::reg_idx_t rt_o,
    output mips_pkg::reg_idx_t dst_o,
    input  mips_pkg::word_t    jump_target_pc_i,
    output mips_pkg::word_t    jump_target_o
);
    import mips_pkg::*;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rd;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign rs_o   = instr_i[25:21];
    assign rt_o   = instr_i[20:16];
    assign rd     = instr_i[15:11];

    always_comb begin
        ctrl_o = '0; // unknown encodings fall out as a no-op
        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    default: ctrl_o.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.dst_rt    = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.alu_op    = ALU_LUI;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.dst_rt    = 1'b1;
            end
            OP_LW: begin
                ctrl_o.use_imm   = 1'b1; // address = rs + offset
                ctrl_o.reg_write = 1'b1;
                ctrl_o.mem_read  = 1'b1;
                ctrl_o.dst_rt    = 1'b1;
            end
            OP_SW: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.mem_write = 1'b1;
            end
            OP_BEQ: begin
                ctrl_o.alu_op    = ALU_SUB;
                ctrl_o.branch_eq = 1'b1;
            end
            OP_BNE: begin
                ctrl_o.alu_op    = ALU_SUB;
                ctrl_o.branch_ne = 1'b1;
            end
            OP_J: ctrl_o.jump = 1'b1;
            default: ;
        endcase
    end

    // lui only needs the low half, so it takes the zero-extended form
    assign imm_o = (opcode == OP_LUI) ? {16'h0000, instr_i[15:0]}
                                      : {{16{instr_i[15]}}, instr_i[15:0]};

    assign dst_o = ctrl_o.dst_rt ? rt_o : rd;

    // region of the delay slot, not of the jump itself
    assign jump_target_o = {jump_target_pc_i[31:28], instr_i[25:0], 2'b00};

endmodule

/* mips_regfile.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module mips_regfile (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               we_i,
    input  mips_pkg::reg_idx_t waddr_i,
    input  mips_pkg::word_t    wdata_i,
    input  mips_pkg::reg_idx_t raddr_a_i,
    input  mips_pkg::reg_idx_t raddr_b_i,
    output mips_pkg::word_t    rdata_a_o,
    output mips_pkg::word_t    rdata_b_o
);
    import mips_pkg::*;

    word_t regs_q [`MIPS_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i; // $zero never written
        end
    end

    // writeback of this cycle wins over the stored copy
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (we_i && idx == waddr_i) begin
            return wdata_i;
        end
        return regs_q[idx];
    endfunction

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

/* mips_hazard.sv */
`timescale 1ns/100ps

module mips_hazard (
    input  mips_pkg::reg_idx_t ex_rs_i,
    input  mips_pkg::reg_idx_t ex_rt_i,
    input  mips_pkg::reg_idx_t mem_dst_i,
    input  logic               mem_we_i,
    input  mips_pkg::reg_idx_t wb_dst_i,
    input  logic               wb_we_i,
    input  logic               ex_mem_read_i,
    input  mips_pkg::reg_idx_t ex_dst_i,
    input  mips_pkg::reg_idx_t id_rs_i,
    input  mips_pkg::reg_idx_t id_rt_i,
    input  logic               branch_taken_i,
    output mips_pkg::fwd_sel_e fwd_a_o,
    output mips_pkg::fwd_sel_e fwd_b_o,
    output logic               stall_o,
    output logic               flush_id_o
);
    import mips_pkg::*;

    // the younger producer in memory wins over writeback
    function automatic fwd_sel_e pick_source(input reg_idx_t src);
        if (mem_we_i && mem_dst_i != '0 && mem_dst_i == src) begin
            return FWD_FROM_MEM;
        end
        if (wb_we_i && wb_dst_i != '0 && wb_dst_i == src) begin
            return FWD_FROM_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick_source(ex_rs_i);
        fwd_b_o = pick_source(ex_rt_i);
    end

    // load data is only ready in writeback, one cycle too late for execute
    assign stall_o = ex_mem_read_i && ex_dst_i != '0
                     && (ex_dst_i == id_rs_i || ex_dst_i == id_rt_i);

    assign flush_id_o = branch_taken_i; // drops the fetch after the delay slot

    // a load and a branch can never share the execute stage
    a_no_stall_on_flush: assert final (!(stall_o && flush_id_o));

endmodule

/* mips_alu.sv */
`timescale 1ns/100ps

module mips_alu (
    input  mips_pkg::alu_op_e op_i,
    input  mips_pkg::word_t   a_i,
    input  mips_pkg::word_t   b_i,
    output mips_pkg::word_t   result_o,
    output logic              equal_o
);
    import mips_pkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i; // wraps, no overflow trap
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_LUI:    result_o = {b_i[15:0], 16'h0000};
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

    assign equal_o = (a_i == b_i); // branch compare on forwarded operands

endmodule

/* mycpu_top.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module mycpu_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    output logic                     inst_sram_en_o,
    output logic [`MIPS_BE_W-1:0]    inst_sram_wen_o,
    output mips_pkg::word_t          inst_sram_addr_o,
    output mips_pkg::word_t          inst_sram_wdata_o,
    input  mips_pkg::word_t          inst_sram_rdata_i,
    output logic                     data_sram_en_o,
    output logic [`MIPS_BE_W-1:0]    data_sram_wen_o,
    output mips_pkg::word_t          data_sram_addr_o,
    output mips_pkg::word_t          data_sram_wdata_o,
    input  mips_pkg::word_t          data_sram_rdata_i,
    output mips_pkg::word_t          debug_wb_pc_o,
    output logic [`MIPS_BE_W-1:0]    debug_wb_rf_wen_o,
    output mips_pkg::reg_idx_t       debug_wb_rf_wnum_o,
    output mips_pkg::word_t          debug_wb_rf_wdata_o
);
    import mips_pkg::*;

    ifid_t  ifid_q;
    idex_t  idex_q;
    exmem_t exmem_q;
    memwb_t memwb_q;

    word_t    pc;
    word_t    next_pc;
    word_t    if_instr;
    word_t    instr_hold_q;
    logic     fetch_on_q;
    logic     stall_q;
    ctrl_t    id_ctrl;
    word_t    id_imm;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    reg_idx_t id_dst;
    word_t    id_rs_val;
    word_t    id_rt_val;
    logic     id_issue;
    word_t    jump_target;
    logic     jump;
    logic     stall;
    logic     flush_id;
    logic     branch_taken;
    word_t    branch_target;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    ex_a;
    word_t    ex_b;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_equal;
    word_t    wb_result;
    logic     trace_we;

    mips_fetch u_fetch (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall),
        .jump_i          (jump),
        .jump_target_i   (jump_target),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (pc),
        .next_pc_o       (next_pc)
    );

    assign inst_sram_en_o    = arst_n_i && !stall;
    assign inst_sram_wen_o   = '0;
    assign inst_sram_addr_o  = next_pc; // no translation
    assign inst_sram_wdata_o = '0;

    // sram output is not refreshed while stalled so the word is kept aside
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_on_q <= 1'b0;
            stall_q    <= 1'b0;
        end else begin
            fetch_on_q <= 1'b1; // first request went out at this edge
            stall_q    <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            instr_hold_q <= inst_sram_rdata_i;
        end
    end

    assign if_instr = stall_q ? instr_hold_q : inst_sram_rdata_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ifid_q <= '0;
        end else if (!stall) begin
            ifid_q.valid <= fetch_on_q && !flush_id;
            ifid_q.pc    <= pc;
            ifid_q.instr <= if_instr;
        end
    end

    mips_decoder u_decoder (
        .instr_i          (ifid_q.instr),
        .ctrl_o           (id_ctrl),
        .imm_o            (id_imm),
        .rs_o             (id_rs),
        .rt_o             (id_rt),
        .dst_o            (id_dst),
        .jump_target_pc_i (ifid_q.pc + 32'd4),
        .jump_target_o    (jump_target)
    );

    assign jump = ifid_q.valid && id_ctrl.jump; // resolved in decode while the delay slot sits in IF

    mips_regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (memwb_q.valid && memwb_q.reg_write),
        .waddr_i   (memwb_q.dst),
        .wdata_i   (wb_result),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .rdata_a_o (id_rs_val),
        .rdata_b_o (id_rt_val)
    );

    mips_hazard u_hazard (
        .ex_rs_i        (idex_q.rs),
        .ex_rt_i        (idex_q.rt),
        .mem_dst_i      (exmem_q.dst),
        .mem_we_i       (exmem_q.valid && exmem_q.ctrl.reg_write),
        .wb_dst_i       (memwb_q.dst),
        .wb_we_i        (memwb_q.valid && memwb_q.reg_write),
        .ex_mem_read_i  (idex_q.valid && idex_q.ctrl.mem_read),
        .ex_dst_i       (idex_q.dst),
        .id_rs_i        (id_rs),
        .id_rt_i        (id_rt),
        .branch_taken_i (branch_taken),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .stall_o        (stall),
        .flush_id_o     (flush_id)
    );

    assign id_issue = ifid_q.valid && !stall; // bubble on load-use

    // bubbles enter execute with all controls cleared
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idex_q <= '0;
        end else begin
            idex_q <= '{
                valid:  id_issue,
                pc:     ifid_q.pc,
                ctrl:   id_issue ? id_ctrl : '0,
                rs:     id_rs,
                rt:     id_rt,
                rs_val: id_rs_val,
                rt_val: id_rt_val,
                imm:    id_imm,
                dst:    id_dst
            };
        end
    end

    function automatic word_t pick_operand(input fwd_sel_e sel, input word_t reg_val,
                                           input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_FROM_MEM: return mem_val;
            FWD_FROM_WB:  return wb_val;
            default:      return reg_val;
        endcase
    endfunction

    assign ex_a  = pick_operand(fwd_a, idex_q.rs_val, exmem_q.alu_result, wb_result);
    assign ex_b  = pick_operand(fwd_b, idex_q.rt_val, exmem_q.alu_result, wb_result);
    assign alu_b = idex_q.ctrl.use_imm ? idex_q.imm : ex_b;

    mips_alu u_alu (
        .op_i     (idex_q.ctrl.alu_op),
        .a_i      (ex_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .equal_o  (alu_equal)
    );

    assign branch_taken = idex_q.valid
                          && ((idex_q.ctrl.branch_eq && alu_equal)
                              || (idex_q.ctrl.branch_ne && !alu_equal));
    assign branch_target = idex_q.pc + 32'd4 + {idex_q.imm[29:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exmem_q <= '0;
        end else begin
            exmem_q <= '{
                valid:      idex_q.valid,
                pc:         idex_q.pc,
                ctrl:       idex_q.ctrl,
                alu_result: alu_result,
                store_data: ex_b, // forwarded rt rather than the immediate
                dst:        idex_q.dst
            };
        end
    end

    assign data_sram_en_o    = exmem_q.ctrl.mem_read || exmem_q.ctrl.mem_write;
    assign data_sram_wen_o   = {`MIPS_BE_W{exmem_q.ctrl.mem_write}};
    assign data_sram_addr_o  = exmem_q.alu_result;
    assign data_sram_wdata_o = exmem_q.store_data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            memwb_q <= '0;
        end else begin
            memwb_q <= '{
                valid:      exmem_q.valid,
                pc:         exmem_q.pc,
                reg_write:  exmem_q.ctrl.reg_write,
                mem_read:   exmem_q.ctrl.mem_read,
                alu_result: exmem_q.alu_result,
                dst:        exmem_q.dst
            };
        end
    end

    // load word arrives the cycle after the request
    assign wb_result = memwb_q.mem_read ? data_sram_rdata_i : memwb_q.alu_result;

    assign trace_we            = memwb_q.valid && memwb_q.reg_write && memwb_q.dst != '0;
    assign debug_wb_pc_o       = memwb_q.pc;
    assign debug_wb_rf_wen_o   = {`MIPS_BE_W{trace_we}};
    assign debug_wb_rf_wnum_o  = memwb_q.dst;
    assign debug_wb_rf_wdata_o = wb_result;

    // a request always belongs to a live memory-stage instruction
    a_dsram_en_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i) data_sram_en_o |-> exmem_q.valid
    );

endmodule

/* tb_sram.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module tb_sram #(
    parameter int DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  load_i,
    input  mips_pkg::word_t       init_i [DEPTH],
    input  logic                  en_i,
    input  logic [`MIPS_BE_W-1:0] wen_i,
    input  mips_pkg::word_t       addr_i,
    input  mips_pkg::word_t       wdata_i,
    output mips_pkg::word_t       rdata_o
);
    import mips_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    word_t            rdata_q = '0;
    logic [IDX_W-1:0] idx;

    assign idx = addr_i[IDX_W+1:2]; // word index, upper address bits alias

    always @(posedge clk) begin
        if (load_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= init_i[i];
            end
        end else if (en_i) begin
            for (int b = 0; b < `MIPS_BE_W; b++) begin
                if (wen_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
            rdata_q <= mem[idx]; // old word on a write, new word next cycle
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* tb_mycpu.sv */
`timescale 1ns/100ps

`include "mips_macros.svh"

module tb_mycpu;
    import mips_pkg::*;

    localparam int MEM_DEPTH    = 256;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 40; // cycles allowed between two trace entries
    localparam int QUIET_CYCLES = 30;
    localparam int SEED         = 32'hde3b;

    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2A;

    typedef struct packed {
        word_t    pc;
        reg_idx_t wnum;
        word_t    wdata;
    } trace_t;

    logic                  clk;
    logic                  arst_n;
    logic                  mem_load;
    logic                  inst_en;
    logic [`MIPS_BE_W-1:0] inst_wen;
    word_t                 inst_addr;
    word_t                 inst_wdata;
    word_t                 inst_rdata;
    logic                  data_en;
    logic [`MIPS_BE_W-1:0] data_wen;
    word_t                 data_addr;
    word_t                 data_wdata;
    word_t                 data_rdata;
    word_t                 dbg_pc;
    logic [`MIPS_BE_W-1:0] dbg_wen;
    reg_idx_t              dbg_wnum;
    word_t                 dbg_wdata;

    word_t  imem_init [MEM_DEPTH];
    word_t  dmem_init [MEM_DEPTH];
    trace_t trace_q [$];
    string  name_q [$];

    mycpu_top DUT (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .inst_sram_en_o      (inst_en),
        .inst_sram_wen_o     (inst_wen),
        .inst_sram_addr_o    (inst_addr),
        .inst_sram_wdata_o   (inst_wdata),
        .inst_sram_rdata_i   (inst_rdata),
        .data_sram_en_o      (data_en),
        .data_sram_wen_o     (data_wen),
        .data_sram_addr_o    (data_addr),
        .data_sram_wdata_o   (data_wdata),
        .data_sram_rdata_i   (data_rdata),
        .debug_wb_pc_o       (dbg_pc),
        .debug_wb_rf_wen_o   (dbg_wen),
        .debug_wb_rf_wnum_o  (dbg_wnum),
        .debug_wb_rf_wdata_o (dbg_wdata)
    );

    tb_sram #(.DEPTH(MEM_DEPTH)) u_imem (
        .clk     (clk),
        .load_i  (mem_load),
        .init_i  (imem_init),
        .en_i    (inst_en),
        .wen_i   (inst_wen),
        .addr_i  (inst_addr),
        .wdata_i (inst_wdata),
        .rdata_o (inst_rdata)
    );

    tb_sram #(.DEPTH(MEM_DEPTH)) u_dmem (
        .clk     (clk),
        .load_i  (mem_load),
        .init_i  (dmem_init),
        .en_i    (data_en),
        .wen_i   (data_wen),
        .addr_i  (data_addr),
        .wdata_i (data_wdata),
        .rdata_o (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t pc_of(input int idx);
        return `MIPS_RESET_PC + word_t'(idx) * 32'd4;
    endfunction

    function automatic word_t r_type(input reg_idx_t rs, input reg_idx_t rt,
                                     input reg_idx_t rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_idx_t rs,
                                     input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input int idx);
        word_t target;
        target = pc_of(idx);
        return {OP_J, target[27:2]};
    endfunction

    function automatic word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t slt_value(input word_t a, input word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic void expect_write(input string name, input int idx,
                                         input reg_idx_t wnum, input word_t wdata);
        trace_t entry;
        entry.pc    = pc_of(idx);
        entry.wnum  = wnum;
        entry.wdata = wdata;
        trace_q.push_back(entry);
        name_q.push_back(name);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected,
                             input reg_idx_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle
    task automatic wait_write(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (dbg_wen != '1) begin
            if (waited >= WAIT_LIMIT) begin
                stop_on_error($sformatf("no register write for %s within %0d cycles",
                                        name, WAIT_LIMIT));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic expect_quiet();
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(negedge clk);
            if (dbg_wen != '0) begin
                stop_on_error($sformatf("unexpected register write at pc %h after the trace",
                                        dbg_pc));
            end
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem_init[i] = i_type(OP_ADDIU, 5'd0, 5'd0, 16'(i)); // writes $zero only
            dmem_init[i] = $urandom();
        end
        imem_init[0]  = i_type(OP_ADDIU, 5'd0, 5'd1, 16'h0005);
        imem_init[1]  = i_type(OP_ADDIU, 5'd0, 5'd2, 16'hFFFD);
        imem_init[2]  = r_type(5'd1, 5'd2, 5'd3, FN_ADDU); // r2 from mem, r1 from wb
        imem_init[3]  = r_type(5'd3, 5'd1, 5'd4, FN_SUBU);
        imem_init[4]  = i_type(OP_LUI, 5'd0, 5'd5, 16'h1234);
        imem_init[5]  = r_type(5'd5, 5'd1, 5'd6, FN_OR);
        imem_init[6]  = r_type(5'd6, 5'd5, 5'd7, FN_AND);
        imem_init[7]  = r_type(5'd2, 5'd1, 5'd8, FN_SLT);
        imem_init[8]  = r_type(5'd1, 5'd2, 5'd9, FN_SLT);
        imem_init[9]  = i_type(OP_ADDIU, 5'd0, 5'd10, 16'h0040); // data base
        imem_init[10] = i_type(OP_SW, 5'd10, 5'd6, 16'h0000);
        imem_init[11] = i_type(OP_LW, 5'd10, 5'd11, 16'h0000);
        imem_init[12] = r_type(5'd11, 5'd1, 5'd12, FN_ADDU); // load-use
        imem_init[13] = i_type(OP_LW, 5'd10, 5'd13, 16'h0008);
        imem_init[14] = i_type(OP_BEQ, 5'd1, 5'd1, 16'h0003); // taken, to 18
        imem_init[15] = i_type(OP_ADDIU, 5'd0, 5'd14, 16'h0077); // delay slot
        imem_init[16] = i_type(OP_ADDIU, 5'd0, 5'd15, 16'h0099); // flushed
        imem_init[17] = i_type(OP_ADDIU, 5'd0, 5'd15, 16'h00AA);
        imem_init[18] = i_type(OP_BNE, 5'd1, 5'd1, 16'h0005); // falls through
        imem_init[19] = i_type(OP_ADDIU, 5'd0, 5'd16, 16'h0011);
        imem_init[20] = i_type(OP_ADDIU, 5'd0, 5'd17, 16'h0022);
        imem_init[21] = j_type(24);
        imem_init[22] = i_type(OP_ADDIU, 5'd0, 5'd18, 16'h0033); // delay slot
        imem_init[23] = i_type(OP_ADDIU, 5'd0, 5'd19, 16'h0044); // never fetched
        imem_init[24] = i_type(OP_ADDIU, 5'd13, 5'd20, 16'h0001);
        imem_init[25] = j_type(25); // park here
    endtask

    task automatic build_trace();
        word_t r1;
        word_t r2;
        word_t r3;
        word_t r5;
        word_t r6;
        word_t r13;
        r1  = sext(16'h0005);
        r2  = sext(16'hFFFD);
        r3  = r1 + r2;
        r5  = {16'h1234, 16'h0000};
        r6  = r5 | r1;
        r13 = dmem_init[18]; // word at 0x48
        expect_write("addiu r1", 0, 5'd1, r1);
        expect_write("addiu r2", 1, 5'd2, r2);
        expect_write("addu r3", 2, 5'd3, r3);
        expect_write("subu r4", 3, 5'd4, r3 - r1);
        expect_write("lui r5", 4, 5'd5, r5);
        expect_write("or r6", 5, 5'd6, r6);
        expect_write("and r7", 6, 5'd7, r6 & r5);
        expect_write("slt r8", 7, 5'd8, slt_value(r2, r1));
        expect_write("slt r9", 8, 5'd9, slt_value(r1, r2));
        expect_write("addiu r10", 9, 5'd10, sext(16'h0040));
        expect_write("lw r11", 11, 5'd11, r6);
        expect_write("addu r12", 12, 5'd12, r6 + r1);
        expect_write("lw r13", 13, 5'd13, r13);
        expect_write("beq slot r14", 15, 5'd14, sext(16'h0077));
        expect_write("bne slot r16", 19, 5'd16, sext(16'h0011));
        expect_write("addiu r17", 20, 5'd17, sext(16'h0022));
        expect_write("j slot r18", 22, 5'd18, sext(16'h0033));
        expect_write("addiu r20", 24, 5'd20, r13 + sext(16'h0001));
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n   = 1'b0;
        mem_load = 1'b1;
        load_memories();
        build_trace();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            mem_load <= 1'b0; // memories copied at the first edge
            @(negedge clk);
            if (inst_en || data_en || dbg_wen != '0) begin
                stop_on_error("sram enable or debug write active while reset is held");
            end
        end
        @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < trace_q.size(); n++) begin
            wait_write(name_q[n]);
            check_word({name_q[n], " pc"}, trace_q[n].pc, dbg_pc);
            check_reg({name_q[n], " wnum"}, trace_q[n].wnum, dbg_wnum);
            check_word({name_q[n], " wdata"}, trace_q[n].wdata, dbg_wdata);
        end
        expect_quiet();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
mips_pkg.sv
mips_fetch.sv
mips_decoder.sv
mips_regfile.sv
mips_hazard.sv
mips_alu.sv
mycpu_top.sv
tb_sram.sv
tb_mycpu.sv

/* Makefile */
# Verilator build and run for the pipelined MIPS core testbench

VERILATOR  ?= verilator
TOP        ?= tb_mycpu
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
